//--- alu_flags.sv
// ALU with AND/OR/SUB/ADD, N/Z/C/V computation and the flag register
`timescale 1ns/10ps

module alu_flags import isa_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  alu_op_t           op,
  input  logic              set_flags,
  output logic [DATA_W-1:0] result,
  output flags_t            flags
);

  logic [DATA_W:0] wide;  // Carry out in the top bit
  flags_t          next_flags;

  always_comb begin
    case (op)
      ALU_AND: wide = {1'b0, a & b};  // Carry cleared
      ALU_OR:  wide = {1'b0, a | b};
      ALU_SUB: wide = {1'b0, a} - {1'b0, b};
      default: wide = {1'b0, a} + {1'b0, b};
    endcase
  end

  assign result = wide[DATA_W-1:0];

  always_comb begin
    next_flags.n = result[DATA_W-1];
    next_flags.z = (result == '0);
    next_flags.c = wide[DATA_W];
    // Same operand signs but the result sign flips
    next_flags.v = (a[DATA_W-1] == b[DATA_W-1]) && (result[DATA_W-1] != a[DATA_W-1]);
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else if (set_flags) begin
      flags <= next_flags;
    end
  end

endmodule

//--- data_memory.sv
// Data memory: byte array with big-endian word read and synchronous word write
`timescale 1ns/10ps

module data_memory import isa_pkg::*; #(
  parameter int DMEM_ADDR_W = 8
) (
  input  logic                   clk,
  input  logic [DMEM_ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0]      wdata,
  input  logic                   we,
  output logic [DATA_W-1:0]      rdata
);

  logic [7:0]             mem [2**DMEM_ADDR_W];
  logic [DMEM_ADDR_W-1:0] addr1;  // Wrap at the top of memory
  logic [DMEM_ADDR_W-1:0] addr2;
  logic [DMEM_ADDR_W-1:0] addr3;

  assign addr1 = addr + DMEM_ADDR_W'(1);
  assign addr2 = addr + DMEM_ADDR_W'(2);
  assign addr3 = addr + DMEM_ADDR_W'(3);

  assign rdata = {mem[addr], mem[addr1], mem[addr2], mem[addr3]};  // MSB first

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr]  <= wdata[31:24];
      mem[addr1] <= wdata[23:16];
      mem[addr2] <= wdata[15:8];
      mem[addr3] <= wdata[7:0];
    end
  end

endmodule

//--- flist.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
instr_queue.sv
register_file.sv
hazard_unit.sv
operand_shifter.sv
alu_flags.sv
data_memory.sv
pipelined_core.sv
tb_core.sv

//--- hazard_unit.sv
// Hazard unit: per-operand forwarding select and load-use stall detection
`timescale 1ns/10ps

module hazard_unit import isa_pkg::*, pipe_pkg::*; (
  input  src_use_t src,
  input  reg_idx_t ex_rd,
  input  reg_idx_t mem_rd,
  input  reg_idx_t wb_rd,
  input  logic     ex_wen,
  input  logic     mem_wen,
  input  logic     wb_wen,
  input  logic     ex_load,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b,
  output fwd_sel_t fwd_c,
  output logic     stall
);

  // Newest writer wins
  function automatic fwd_sel_t pick_src(logic used, reg_idx_t idx);
    fwd_sel_t sel;
    sel = FWD_RF;
    if (used) begin
      if (ex_wen && idx == ex_rd) begin
        sel = FWD_EX;
      end else if (mem_wen && idx == mem_rd) begin
        sel = FWD_MEM;
      end else if (wb_wen && idx == wb_rd) begin
        sel = FWD_WB;
      end
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a = pick_src(src.a_used, src.a);
    fwd_b = pick_src(src.b_used, src.b);
    fwd_c = pick_src(src.c_used, src.c);
    // Load data is not ready until MEM, so wait one cycle
    stall = ex_load && ((src.a_used && src.a == ex_rd) ||
                        (src.b_used && src.b == ex_rd) ||
                        (src.c_used && src.c == ex_rd));
  end

endmodule

//--- instr_queue.sv
// Instruction queue: circular FIFO fed by a credit channel, one credit back per issued entry
`timescale 1ns/10ps

module instr_queue import isa_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   push,
  input  instr_t push_data,
  input  logic   pop,
  output instr_t head,
  output logic   not_empty,
  output logic   credit_return
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  instr_t           buffer [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
    if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
      return '0;  // Depth need not be a power of two
    end
    return p + 1'b1;
  endfunction

  assign not_empty     = (count != '0);
  assign do_pop        = pop && not_empty;
  assign head          = buffer[rd_ptr];
  assign credit_return = do_pop;  // Credit leaves with the entry

  always_ff @(posedge clk) begin
    if (push) begin
      buffer[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

//--- isa_pkg.sv
// ISA package: instruction word layout, opcode enums, flags and register index types
package isa_pkg;

  localparam int DATA_W   = 32;  // Word width
  localparam int NUM_REGS = 16;

  typedef logic [3:0] reg_idx_t;

  typedef enum logic [1:0] {
    ALU_AND = 2'b00,
    ALU_OR  = 2'b01,
    ALU_SUB = 2'b10,
    ALU_ADD = 2'b11
  } alu_op_t;

  typedef enum logic [1:0] {
    AM_ROT_IMM   = 2'b00,  // imm8 rotated right by 2*rot4
    AM_REG       = 2'b01,  // Rm as is
    AM_ZEXT_IMM  = 2'b10,  // imm12 zero-extended
    AM_SHIFT_REG = 2'b11   // Rm shifted by imm5, kind in bits 6..5
  } addr_mode_t;

  typedef enum logic [1:0] {
    K_NOP   = 2'b00,
    K_ALU   = 2'b01,
    K_LOAD  = 2'b10,
    K_STORE = 2'b11
  } instr_kind_t;

  // Operand field: Rm [3:0], shift kind [6:5], shift amount [11:7]
  typedef struct packed {
    logic [4:0]  spare;    // Must be zero
    instr_kind_t kind;
    addr_mode_t  mode;
    alu_op_t     op;
    logic        s;        // Update flags
    reg_idx_t    rn;
    reg_idx_t    rd;
    logic [11:0] operand;
  } instr_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

endpackage

//--- operand_shifter.sv
// Operand shifter: second operand from rotated or zero-extended immediate, or shifted Rm
`timescale 1ns/10ps

module operand_shifter import isa_pkg::*; (
  input  logic [DATA_W-1:0] rm_val,
  input  logic [11:0]       operand,
  input  addr_mode_t        mode,
  output logic [DATA_W-1:0] op_b
);

  logic [2*DATA_W-1:0] imm_pair;  // Doubled word makes a right shift a rotate
  logic [2*DATA_W-1:0] rm_pair;
  logic [2*DATA_W-1:0] imm_rot;
  logic [2*DATA_W-1:0] rm_rot;
  logic [4:0]          shamt;

  assign shamt    = operand[11:7];
  assign imm_pair = {2{{(DATA_W-8){1'b0}}, operand[7:0]}};
  assign rm_pair  = {rm_val, rm_val};
  assign imm_rot  = imm_pair >> {operand[11:8], 1'b0};  // Twice the rotate field
  assign rm_rot   = rm_pair >> shamt;

  always_comb begin
    case (mode)
      AM_ROT_IMM:  op_b = imm_rot[DATA_W-1:0];
      AM_REG:      op_b = rm_val;
      AM_ZEXT_IMM: op_b = {{(DATA_W-12){1'b0}}, operand};
      default: begin
        case (operand[6:5])
          2'b00:   op_b = rm_val << shamt;             // LSL
          2'b01:   op_b = rm_val >> shamt;             // LSR
          2'b10:   op_b = $signed(rm_val) >>> shamt;   // ASR
          default: op_b = rm_rot[DATA_W-1:0];          // ROR
        endcase
      end
    endcase
  end

endmodule

//--- pipe_pkg.sv
// Pipeline package: stage payloads, forwarding select and write-back port types
package pipe_pkg;
  import isa_pkg::*;

  typedef struct packed {
    logic              valid;
    instr_kind_t       kind;
    alu_op_t           op;
    logic              s;
    reg_idx_t          rd;
    logic [DATA_W-1:0] op_a;     // Rn value
    logic [DATA_W-1:0] op_b;     // Shifter output
    logic [DATA_W-1:0] st_data;  // Rd value for stores
  } id_ex_t;

  typedef struct packed {
    logic              valid;
    instr_kind_t       kind;
    reg_idx_t          rd;
    logic [DATA_W-1:0] result;   // ALU result or memory address
    logic [DATA_W-1:0] st_data;
  } ex_mem_t;

  typedef struct packed {
    logic              wen;
    reg_idx_t          rd;
    logic [DATA_W-1:0] data;
  } mem_wb_t;

  // Source registers of the instruction in decode
  typedef struct packed {
    logic     a_used;
    reg_idx_t a;   // Rn
    logic     b_used;
    reg_idx_t b;   // Rm
    logic     c_used;
    reg_idx_t c;   // Rd of a store
  } src_use_t;

  typedef enum logic [1:0] {
    FWD_RF  = 2'b00,
    FWD_EX  = 2'b01,
    FWD_MEM = 2'b10,
    FWD_WB  = 2'b11
  } fwd_sel_t;

  typedef struct packed {
    logic              valid;
    reg_idx_t          rd;
    logic [DATA_W-1:0] data;
  } wb_t;

endpackage

//--- pipelined_core.sv
// Pipelined core top: queue-fed decode, forwarding, ID/EX/MEM/WB stage registers
`timescale 1ns/10ps

module pipelined_core import isa_pkg::*, pipe_pkg::*; #(
  parameter int QUEUE_DEPTH = 4,
  parameter int DMEM_ADDR_W = 8
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   instr_valid,
  input  instr_t instr_in,
  output logic   credit_return,
  output wb_t    wb_out,
  output flags_t flags_out
);

  instr_t            head;
  logic              not_empty;
  logic              stall;
  logic              pop;
  src_use_t          src;
  fwd_sel_t          fwd_a, fwd_b, fwd_c;
  logic [DATA_W-1:0] pa, pb, pc_data;
  logic [DATA_W-1:0] val_a, val_m, val_d;  // Rn, Rm, Rd after forwarding
  logic [DATA_W-1:0] shifted;
  logic [DATA_W-1:0] alu_result;
  logic [DATA_W-1:0] dmem_rdata;
  logic [DATA_W-1:0] mem_value;
  logic              is_op;
  id_ex_t            id_ex;
  ex_mem_t           ex_mem;
  mem_wb_t           mem_wb;

  assign pop = not_empty && !stall;

  instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk, .reset, .push(instr_valid), .push_data(instr_in), .pop,
    .head, .not_empty, .credit_return
  );

  // Source use gated by a present head
  assign is_op      = not_empty && head.kind != K_NOP;
  assign src.a      = head.rn;
  assign src.a_used = is_op;
  assign src.b      = head.operand[3:0];
  assign src.b_used = is_op && (head.mode == AM_REG || head.mode == AM_SHIFT_REG);
  assign src.c      = head.rd;
  assign src.c_used = not_empty && head.kind == K_STORE;

  register_file u_rf (
    .clk, .reset, .ra(src.a), .rb(src.b), .rc(src.c), .wr(mem_wb),
    .pa, .pb, .pc_data
  );

  hazard_unit u_hazard (
    .src,
    .ex_rd(id_ex.rd), .mem_rd(ex_mem.rd), .wb_rd(mem_wb.rd),
    .ex_wen(id_ex.valid && (id_ex.kind == K_ALU || id_ex.kind == K_LOAD)),
    .mem_wen(ex_mem.valid && (ex_mem.kind == K_ALU || ex_mem.kind == K_LOAD)),
    .wb_wen(mem_wb.wen),
    .ex_load(id_ex.valid && id_ex.kind == K_LOAD),
    .fwd_a, .fwd_b, .fwd_c, .stall
  );

  function automatic logic [DATA_W-1:0] fwd_value(fwd_sel_t sel, logic [DATA_W-1:0] rf_val);
    case (sel)
      FWD_EX:  return alu_result;
      FWD_MEM: return mem_value;  // Load data already read
      FWD_WB:  return mem_wb.data;
      default: return rf_val;
    endcase
  endfunction

  always_comb begin
    val_a = fwd_value(fwd_a, pa);
    val_m = fwd_value(fwd_b, pb);
    val_d = fwd_value(fwd_c, pc_data);
  end

  operand_shifter u_shifter (.rm_val(val_m), .operand(head.operand), .mode(head.mode),
                             .op_b(shifted));

  alu_flags u_alu (
    .clk, .reset, .a(id_ex.op_a), .b(id_ex.op_b), .op(id_ex.op),
    .set_flags(id_ex.valid && id_ex.kind == K_ALU && id_ex.s),
    .result(alu_result), .flags(flags_out)
  );

  data_memory #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_dmem (
    .clk, .addr(ex_mem.result[DMEM_ADDR_W-1:0]), .wdata(ex_mem.st_data),
    .we(ex_mem.valid && ex_mem.kind == K_STORE), .rdata(dmem_rdata)
  );

  assign mem_value = (ex_mem.kind == K_LOAD) ? dmem_rdata : ex_mem.result;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end else begin
      id_ex.valid   <= pop;  // Stall or empty queue gives a bubble
      id_ex.kind    <= head.kind;
      id_ex.op      <= (head.kind == K_ALU) ? head.op : ALU_ADD;  // Address add otherwise
      id_ex.s       <= head.s && head.kind == K_ALU;
      id_ex.rd      <= head.rd;
      id_ex.op_a    <= val_a;
      id_ex.op_b    <= shifted;
      id_ex.st_data <= val_d;

      ex_mem.valid   <= id_ex.valid;
      ex_mem.kind    <= id_ex.kind;
      ex_mem.rd      <= id_ex.rd;
      ex_mem.result  <= alu_result;
      ex_mem.st_data <= id_ex.st_data;

      mem_wb.wen  <= ex_mem.valid && (ex_mem.kind == K_ALU || ex_mem.kind == K_LOAD);
      mem_wb.rd   <= ex_mem.rd;
      mem_wb.data <= mem_value;
    end
  end

  assign wb_out.valid = mem_wb.wen;
  assign wb_out.rd    = mem_wb.rd;
  assign wb_out.data  = mem_wb.data;

endmodule

//--- register_file.sv
// Register file: sixteen 32-bit registers, three combinational read ports, one write port
`timescale 1ns/10ps

module register_file import isa_pkg::*, pipe_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  reg_idx_t          ra,
  input  reg_idx_t          rb,
  input  reg_idx_t          rc,
  input  mem_wb_t           wr,
  output logic [DATA_W-1:0] pa,
  output logic [DATA_W-1:0] pb,
  output logic [DATA_W-1:0] pc_data
);

  logic [DATA_W-1:0]   regs [NUM_REGS];
  logic [NUM_REGS-1:0] wr_sel;  // One-hot write decode

  assign wr_sel = wr.wen ? (NUM_REGS'(1) << wr.rd) : '0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_REGS; i++) begin
        if (wr_sel[i]) begin
          regs[i] <= wr.data;
        end
      end
    end
  end

  // Reads return the value from before a same-cycle write
  assign pa      = regs[ra];
  assign pb      = regs[rb];
  assign pc_data = regs[rc];

endmodule

//--- tb_model.svh
// Reference model for the core: operand forming, data address and in-order instruction execution
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic logic [31:0] model_shift(logic [31:0] rm, logic [11:0] opnd, addr_mode_t mode);
  int          rot;
  int          sh;
  logic [31:0] imm;
  rot = 2 * opnd[11:8];
  sh  = opnd[11:7];
  imm = {24'h0, opnd[7:0]};
  case (mode)
    AM_ROT_IMM:  return (rot == 0) ? imm : ((imm >> rot) | (imm << (32 - rot)));
    AM_REG:      return rm;
    AM_ZEXT_IMM: return {20'h0, opnd};
    default: begin
      case (opnd[6:5])
        2'b00:   return rm << sh;
        2'b01:   return rm >> sh;
        2'b10:   return $signed(rm) >>> sh;  // Sign fills from the left
        default: return (sh == 0) ? rm : ((rm >> sh) | (rm << (32 - sh)));
      endcase
    end
  endcase
endfunction

function automatic logic [DMEM_ADDR_W-1:0] model_addr(instr_t i);
  logic [31:0] sum;
  sum = m_regs[i.rn] + model_shift(m_regs[i.operand[3:0]], i.operand, i.mode);
  return sum[DMEM_ADDR_W-1:0];  // Low bits only, so it wraps
endfunction

function automatic void model_exec(input instr_t i, output bit has_wb, output wb_t w);
  logic [31:0]            a;
  logic [31:0]            b;
  logic [32:0]            wide;
  logic [DMEM_ADDR_W-1:0] ad;
  a = m_regs[i.rn];
  b = model_shift(m_regs[i.operand[3:0]], i.operand, i.mode);
  ad = model_addr(i);
  has_wb = 1'b0;
  w = '0;
  case (i.kind)
    K_ALU: begin
      case (i.op)
        ALU_AND: wide = {1'b0, a & b};
        ALU_OR:  wide = {1'b0, a | b};
        ALU_SUB: wide = {1'b0, a} - {1'b0, b};
        default: wide = {1'b0, a} + {1'b0, b};
      endcase
      if (i.s) begin
        m_flags.n = wide[31];
        m_flags.z = (wide[31:0] == 32'h0);
        m_flags.c = wide[32];
        m_flags.v = (a[31] == b[31]) && (wide[31] != a[31]);
      end
      w.data = wide[31:0];
      has_wb = 1'b1;
    end
    K_LOAD: begin
      for (int k = 0; k < 4; k++) begin
        w.data = {w.data[23:0], m_mem[ad + DMEM_ADDR_W'(k)]};  // First byte is the MSB
      end
      has_wb = 1'b1;
    end
    K_STORE: begin
      for (int k = 0; k < 4; k++) begin
        m_mem[ad + DMEM_ADDR_W'(k)]   = m_regs[i.rd][31-8*k -: 8];
        m_known[ad + DMEM_ADDR_W'(k)] = 1'b1;
      end
    end
    default: ;
  endcase
  if (has_wb) begin
    w.valid = 1'b1;
    w.rd = i.rd;
    m_regs[i.rd] = w.data;
  end
endfunction

`endif

//--- tb_core.sv
// Testbench for the pipelined core: credit-obeying driver, reference model and write-back checker
`timescale 1ns/10ps

module tb_core import isa_pkg::*, pipe_pkg::*; ();

  localparam int QUEUE_DEPTH = 4;
  localparam int DMEM_ADDR_W = 8;
  localparam int N_CHAIN     = 60;   // Dependent ALU chain
  localparam int N_RAND      = 200;  // Mixed random stream

  logic   clk;
  logic   reset;
  logic   instr_valid;
  instr_t instr_in;
  logic   credit_return;
  wb_t    wb_out;
  flags_t flags_out;

  // Model state
  logic [31:0] m_regs [NUM_REGS];
  logic [7:0]  m_mem [2**DMEM_ADDR_W];
  bit          m_known [2**DMEM_ADDR_W];  // Byte written at least once
  flags_t      m_flags;

  wb_t      exp_q[$];
  instr_t   directed[$];
  int       errors;
  int       checked;
  int       sent;
  int       credit_pulses;
  int       cycles;
  int       limit;
  reg_idx_t last_rd;
  reg_idx_t prev_rd;

  `include "tb_model.svh"

  pipelined_core #(.QUEUE_DEPTH(QUEUE_DEPTH), .DMEM_ADDR_W(DMEM_ADDR_W)) dut (
    .clk, .reset, .instr_valid, .instr_in, .credit_return, .wb_out, .flags_out
  );

  always #5 clk = ~clk;

  function automatic instr_t encode(instr_kind_t kind, addr_mode_t mode, alu_op_t op, logic s,
                                    reg_idx_t rd, reg_idx_t rn, logic [11:0] opnd);
    return {5'b0, kind, mode, op, s, rn, rd, opnd};
  endfunction

  function automatic logic [11:0] shift_field(logic [4:0] amt, logic [1:0] kind, reg_idx_t rm);
    return {amt, kind, 1'b0, rm};
  endfunction

  function automatic instr_t random_instr(bit chain);
    instr_t                 i;
    logic [DMEM_ADDR_W-1:0] ad;
    bit                     known;
    i = instr_t'($urandom);
    i.spare = '0;
    if (chain) begin
      i.kind = K_ALU;
      i.rn = last_rd;
      i.operand[3:0] = prev_rd;  // Rm two back when the mode reads it
    end
    if (i.kind == K_LOAD) begin
      ad = model_addr(i);
      known = 1'b1;
      for (int k = 0; k < 4; k++) begin
        known &= m_known[ad + DMEM_ADDR_W'(k)];
      end
      if (!known) begin
        i.kind = K_STORE;  // Word not written yet
      end
    end
    if (i.kind == K_ALU || i.kind == K_LOAD) begin
      prev_rd = last_rd;
      last_rd = i.rd;
    end
    return i;
  endfunction

  task automatic finish_run(input bit timed_out);
    $display("Errors: %0d, results checked: %0d, instructions sent: %0d",
             errors, checked, sent);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  // Driver
  initial begin
    int     credits;
    int     n;
    int     n_total;
    instr_t ins;
    bit     has_wb;
    wb_t    w;
    clk = 1'b0;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr_in = '0;
    void'($urandom(32'h49ef));
    for (int r = 0; r < NUM_REGS; r++) begin
      m_regs[r] = '0;
    end
    m_flags = '0;
    directed.push_back(encode(K_ALU, AM_ROT_IMM, ALU_ADD, 1, 1, 0, 12'h4ff));
    directed.push_back(encode(K_ALU, AM_ZEXT_IMM, ALU_OR, 0, 2, 0, 12'h5a5));
    directed.push_back(encode(K_ALU, AM_ZEXT_IMM, ALU_SUB, 1, 3, 2, 12'h7ff));
    directed.push_back(encode(K_ALU, AM_ROT_IMM, ALU_AND, 1, 4, 3, 12'h1f0));
    directed.push_back(encode(K_ALU, AM_ZEXT_IMM, ALU_ADD, 0, 5, 1, 12'h123));
    directed.push_back(encode(K_ALU, AM_REG, ALU_ADD, 1, 6, 1, 12'h003));
    directed.push_back(encode(K_ALU, AM_SHIFT_REG, ALU_OR, 0, 7, 0, shift_field(4, 0, 3)));
    directed.push_back(encode(K_ALU, AM_SHIFT_REG, ALU_OR, 0, 8, 0, shift_field(7, 1, 3)));
    directed.push_back(encode(K_ALU, AM_SHIFT_REG, ALU_OR, 0, 9, 0, shift_field(12, 2, 3)));
    directed.push_back(encode(K_ALU, AM_SHIFT_REG, ALU_OR, 0, 10, 0, shift_field(9, 3, 5)));
    directed.push_back(encode(K_ALU, AM_SHIFT_REG, ALU_ADD, 0, 11, 2, shift_field(0, 3, 6)));
    directed.push_back(encode(K_STORE, AM_ZEXT_IMM, ALU_ADD, 0, 5, 0, 12'h040));
    directed.push_back(encode(K_LOAD, AM_ZEXT_IMM, ALU_ADD, 0, 12, 0, 12'h040));
    directed.push_back(encode(K_ALU, AM_REG, ALU_ADD, 0, 13, 12, 12'h00c));  // Load-use
    directed.push_back(encode(K_STORE, AM_ZEXT_IMM, ALU_ADD, 0, 6, 0, 12'h0fe));  // Wraps
    directed.push_back(encode(K_LOAD, AM_ZEXT_IMM, ALU_ADD, 0, 14, 0, 12'h0fe));
    directed.push_back(encode(K_ALU, AM_REG, ALU_SUB, 1, 15, 14, 12'h003));
    directed.push_back(encode(K_NOP, AM_REG, ALU_AND, 0, 0, 0, 12'h000));
    directed.push_back(encode(K_ALU, AM_REG, ALU_AND, 0, 1, 15, 12'h00e));
    last_rd = 4'd1;
    prev_rd = 4'd15;
    n_total = directed.size() + N_CHAIN + N_RAND;
    limit = 8 * n_total + 100;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
    n = 0;
    while (n < n_total) begin
      @(posedge clk);
      #1;
      credits = QUEUE_DEPTH - sent + credit_pulses;
      assert (credits >= 0 && credits <= QUEUE_DEPTH) else begin
        errors++;
        $display("Sender credit count out of range (%0d) at %0t", credits, $time);
      end
      if (credits > 0) begin
        if (n < directed.size()) begin
          ins = directed[n];
        end else begin
          ins = random_instr(n < directed.size() + N_CHAIN);
        end
        model_exec(ins, has_wb, w);
        if (has_wb) begin
          exp_q.push_back(w);
        end
        instr_valid = 1'b1;
        instr_in = ins;
        sent++;
        n++;
      end else begin
        instr_valid = 1'b0;  // Out of credits
      end
    end
    @(posedge clk);
    #1 instr_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (QUEUE_DEPTH + 3) @(posedge clk);  // Trailing stores and NOPs leave the queue
    assert (flags_out == m_flags) else begin
      errors++;
      $display("** Error at %0t: flags %b, expected %b", $time, flags_out, m_flags);
    end
    assert (credit_pulses == sent) else begin
      errors++;
      $display("Credit returns (%0d) do not match instructions sent (%0d)", credit_pulses, sent);
    end
    finish_run(1'b0);
  end

  // Checker samples mid-cycle
  always @(negedge clk) begin
    wb_t want;
    if (!reset) begin
      if (credit_return) begin
        credit_pulses++;
      end
      assert (credit_pulses <= sent) else begin
        errors++;
        $display("Credit returned for an instruction never sent at %0t", $time);
      end
      if (wb_out.valid) begin
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("Unexpected write-back to r%0d at %0t", wb_out.rd, $time);
        end
        if (exp_q.size() > 0) begin
          want = exp_q.pop_front();
          checked++;
          assert (wb_out.rd == want.rd && wb_out.data == want.data) else begin
            errors++;
            $display("** Error at %0t: write-back r%0d = %h, expected r%0d = %h",
                     $time, wb_out.rd, wb_out.data, want.rd, want.data);
          end
        end
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      finish_run(1'b1);
    end
  end

endmodule
